//--- feed_pkg.sv
package feed_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Packet format
   ////////////////////////////////////////////////////////////////////////////

   // Upper byte of every header word
   localparam logic [7:0] SYNC_BYTE = 8'hA5;

   // Longest payload in words, carried in the header's lower byte
   localparam int MAX_PAYLOAD = 32;

   localparam int WORD_W = 16;
   localparam int SAMPLE_W = 3;

   ////////////////////////////////////////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////////////////////////////////////////

   // One word from the packet source
   typedef struct packed {
      logic              valid;
      logic [WORD_W-1:0] data;
   } feed_word_t;

   // One output sample
   typedef struct packed {
      logic                valid;
      logic [SAMPLE_W-1:0] data;
   } sample_t;

   // One memory access, the address travels beside it
   typedef struct packed {
      logic              req;
      logic              we;
      logic [WORD_W-1:0] wdata;
   } ram_req_t;

endpackage

//--- payload_ram.sv
`timescale 1ns/1ps

module payload_ram import feed_pkg::*; #(
   parameter int PAYLOAD_DEPTH = 64
) (
   input  logic                              clk_sample,
   input  ram_req_t                          mem_req,
   input  logic [$clog2(PAYLOAD_DEPTH)-1:0]  mem_addr,
   output logic [WORD_W-1:0]                 rd_data
);

   logic [WORD_W-1:0] mem [PAYLOAD_DEPTH];

   // Single port, either a write or a registered read per cycle
   always_ff @(posedge clk_sample) begin
      if (mem_req.req) begin
         if (mem_req.we)
            mem[mem_addr] <= mem_req.wdata;
         else
            rd_data <= mem[mem_addr];
      end
   end

endmodule

//--- buffer_arbiter.sv
`timescale 1ns/1ps

module buffer_arbiter import feed_pkg::*; #(
   parameter int PAYLOAD_DEPTH = 64
) (
   input  logic                              clk_sample,
   input  logic                              reset,
   input  ram_req_t                          wr_req,
   input  logic [$clog2(PAYLOAD_DEPTH)-1:0]  wr_addr,
   input  ram_req_t                          rd_req,
   input  logic [$clog2(PAYLOAD_DEPTH)-1:0]  rd_addr,
   output logic                              wr_grant,
   output logic                              rd_grant,
   output ram_req_t                          mem_req,
   output logic [$clog2(PAYLOAD_DEPTH)-1:0]  mem_addr,
   output logic                              rd_valid
);

   // High when the read side won the last grant
   logic last_rd;

   always_comb begin
      wr_grant = 1'b0;
      rd_grant = 1'b0;
      if (wr_req.req && rd_req.req) begin
         // Tie goes to whoever lost last time
         if (last_rd)
            wr_grant = 1'b1;
         else
            rd_grant = 1'b1;
      end else begin
         wr_grant = wr_req.req;
         rd_grant = rd_req.req;
      end

      mem_req = '0;
      mem_addr = wr_addr;
      if (wr_grant) begin
         mem_req = wr_req;
      end else if (rd_grant) begin
         mem_req = rd_req;
         mem_addr = rd_addr;
      end
   end

   always_ff @(posedge clk_sample) begin
      if (reset) begin
         last_rd <= 1'b0;
         rd_valid <= 1'b0;
      end else begin
         if (rd_grant)
            last_rd <= 1'b1;
         else if (wr_grant)
            last_rd <= 1'b0;
         // Memory read data shows up one cycle after the grant
         rd_valid <= rd_grant;
      end
   end

endmodule

//--- packet_checker.sv
`timescale 1ns/1ps

module packet_checker import feed_pkg::*; #(
   parameter int PAYLOAD_DEPTH = 64
) (
   input  logic                              clk_sample,
   input  logic                              reset,
   input  feed_word_t                        in_word,
   output logic                              credit,
   output ram_req_t                          wr_req,
   output logic [$clog2(PAYLOAD_DEPTH)-1:0]  wr_addr,
   input  logic                              wr_grant,
   input  logic                              read_done,
   output logic [$clog2(PAYLOAD_DEPTH):0]    commit_ptr,
   output logic [8:0]                        packet_count,
   output logic [8:0]                        good_packet_count
);

   localparam int AW = $clog2(PAYLOAD_DEPTH);
   localparam int LW = $clog2(MAX_PAYLOAD + 1);
   // Reads take memory slots during a burst, so the queue must soak up
   // a whole payload without stalling the source
   localparam int STAGE_DEPTH = MAX_PAYLOAD;
   localparam int SW = $clog2(STAGE_DEPTH);

   typedef enum logic [1:0] {ST_HUNT, ST_PAYLOAD, ST_CHECK} state_t;

   state_t            state;
   logic [LW-1:0]     pkt_len;
   logic [LW-1:0]     remain;
   logic [WORD_W-1:0] run_xor;
   logic [AW:0]       alloc_ptr;

   logic [WORD_W-1:0] stage_data [STAGE_DEPTH];
   logic [AW-1:0]     stage_addr [STAGE_DEPTH];
   logic [SW-1:0]     stage_head;
   logic [SW-1:0]     stage_tail;
   logic [SW:0]       stage_count;
   logic [SW:0]       stage_count_next;

   logic              header_ok;
   logic              push;
   logic              pop;
   logic              check;
   logic              sum_ok;
   logic              sum_bad;
   logic              word_ret;

   logic              commit_pend;
   logic [SW:0]       pend_left;
   logic [AW:0]       commit_target;

   logic [AW+1:0]     credit_pend;
   logic [AW+1:0]     credit_add;

   ////////////////////////////////////////////////////////////////////////////
   // Word decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      header_ok = in_word.data[15:8] == SYNC_BYTE &&
                  in_word.data[7:0] != 8'd0 &&
                  in_word.data[7:0] <= 8'(MAX_PAYLOAD);
      push = in_word.valid && state == ST_PAYLOAD;
      pop = wr_req.req && wr_grant;
      check = in_word.valid && state == ST_CHECK;
      sum_ok = check && in_word.data == run_xor;
      sum_bad = check && !sum_ok;
      // Header, checksum and junk words give their credit back at once
      word_ret = in_word.valid && state != ST_PAYLOAD;
      stage_count_next = stage_count + (SW+1)'(push) - (SW+1)'(pop);
      credit_add = (AW+2)'(word_ret) + (AW+2)'(read_done) +
                   (sum_bad ? (AW+2)'(pkt_len) : '0);
   end

   always_ff @(posedge clk_sample) begin
      if (reset) begin
         state <= ST_HUNT;
         pkt_len <= '0;
         remain <= '0;
         run_xor <= '0;
         packet_count <= '0;
         good_packet_count <= '0;
      end else if (in_word.valid) begin
         case (state)
            ST_HUNT: begin
               if (header_ok) begin
                  state <= ST_PAYLOAD;
                  pkt_len <= LW'(in_word.data[7:0]);
                  remain <= LW'(in_word.data[7:0]);
                  run_xor <= '0;
                  packet_count <= packet_count + 9'd1;
               end
            end
            ST_PAYLOAD: begin
               run_xor <= run_xor ^ in_word.data;
               remain <= remain - LW'(1);
               if (remain == LW'(1))
                  state <= ST_CHECK;
            end
            ST_CHECK: begin
               state <= ST_HUNT;
               if (sum_ok)
                  good_packet_count <= good_packet_count + 9'd1;
            end
            default: state <= ST_HUNT;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Staging queue and write pointer
   ////////////////////////////////////////////////////////////////////////////

   assign wr_req = '{req: stage_count != '0, we: 1'b1, wdata: stage_data[stage_head]};
   assign wr_addr = stage_addr[stage_head];

   always_ff @(posedge clk_sample) begin
      if (push) begin
         stage_data[stage_tail] <= in_word.data;
         stage_addr[stage_tail] <= alloc_ptr[AW-1:0];
      end
   end

   always_ff @(posedge clk_sample) begin
      if (reset) begin
         stage_head <= '0;
         stage_tail <= '0;
         stage_count <= '0;
         alloc_ptr <= '0;
      end else begin
         if (push) begin
            stage_tail <= stage_tail + SW'(1);
            alloc_ptr <= alloc_ptr + (AW+1)'(1);
         end
         if (pop)
            stage_head <= stage_head + SW'(1);
         stage_count <= stage_count_next;
         // Rollback, stale queued words land above the packet start and
         // are overwritten by the next packet
         if (sum_bad)
            alloc_ptr <= alloc_ptr - (AW+1)'(pkt_len);
      end
   end

   // Commit once every queued word of the packet has reached memory
   always_ff @(posedge clk_sample) begin
      if (reset) begin
         commit_ptr <= '0;
         commit_pend <= 1'b0;
         pend_left <= '0;
         commit_target <= '0;
      end else if (sum_ok) begin
         if (stage_count_next == '0) begin
            commit_ptr <= alloc_ptr;
            commit_pend <= 1'b0;
         end else begin
            commit_pend <= 1'b1;
            pend_left <= stage_count_next;
            commit_target <= alloc_ptr;
         end
      end else if (commit_pend && pop) begin
         pend_left <= pend_left - (SW+1)'(1);
         if (pend_left == (SW+1)'(1)) begin
            commit_ptr <= commit_target;
            commit_pend <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Credit return, one pulse per cycle
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_sample) begin
      if (reset) begin
         credit_pend <= '0;
         credit <= 1'b0;
      end else begin
         credit <= credit_pend != '0;
         credit_pend <= credit_pend + credit_add - (AW+2)'(credit_pend != '0);
      end
   end

endmodule

//--- sample_unpacker.sv
`timescale 1ns/1ps

module sample_unpacker import feed_pkg::*; #(
   parameter int PAYLOAD_DEPTH = 64
) (
   input  logic                              clk_sample,
   input  logic                              reset,
   input  logic [$clog2(PAYLOAD_DEPTH):0]    commit_ptr,
   output ram_req_t                          rd_req,
   output logic [$clog2(PAYLOAD_DEPTH)-1:0]  rd_addr,
   input  logic                              rd_grant,
   input  logic                              rd_valid,
   input  logic [WORD_W-1:0]                 rd_data,
   output logic                              read_done,
   output sample_t                           sample,
   output logic                              have_data,
   output logic [8:0]                        words_available
);

   localparam int AW = $clog2(PAYLOAD_DEPTH);

   logic [AW:0]   rd_ptr;
   logic [AW:0]   unread;
   logic          in_flight;

   logic [17:0]   sample_buf;
   logic [17:0]   buf_shift;
   logic [17:0]   buf_next;
   logic [17:0]   keep_mask;
   logic [2:0]    sample_count;
   logic [2:0]    count_shift;
   logic [2:0]    count_next;
   logic [1:0]    sample_extra;
   logic [1:0]    extra_next;
   logic          emit;

   ////////////////////////////////////////////////////////////////////////////
   // Word fetch
   ////////////////////////////////////////////////////////////////////////////

   assign unread = commit_ptr - rd_ptr;
   assign words_available = 9'(unread);
   assign have_data = unread != '0;

   // Fetch only when fewer than two samples remain, so the leftover
   // bits never exceed the two extra bits
   assign rd_req = '{req: have_data && sample_count < 3'd2 && !in_flight,
                     we: 1'b0,
                     wdata: '0};
   assign rd_addr = rd_ptr[AW-1:0];
   assign read_done = rd_valid;

   always_ff @(posedge clk_sample) begin
      if (reset) begin
         rd_ptr <= '0;
         in_flight <= 1'b0;
      end else begin
         if (rd_grant) begin
            rd_ptr <= rd_ptr + (AW+1)'(1);
            in_flight <= 1'b1;
         end else if (rd_valid) begin
            in_flight <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Sample shifter
   ////////////////////////////////////////////////////////////////////////////

   assign emit = sample_count != 3'd0;
   assign sample = '{valid: emit, data: sample_buf[SAMPLE_W-1:0]};

   always_comb begin
      buf_shift = emit ? (sample_buf >> SAMPLE_W) : sample_buf;
      count_shift = emit ? sample_count - 3'd1 : sample_count;

      // Leftover bits sit at the bottom of the buffer
      case (sample_extra)
         2'd1:    keep_mask = 18'h00001;
         2'd2:    keep_mask = 18'h00003;
         default: keep_mask = 18'h00000;
      endcase

      buf_next = buf_shift;
      count_next = count_shift;
      extra_next = sample_extra;
      if (rd_valid) begin
         // New word goes above the leftover bits
         buf_next = ({2'b00, rd_data} << sample_extra) | (buf_shift & keep_mask);
         // 16 bits give 5 samples and one spare, the third spare bit
         // completes a sixth
         if (sample_extra == 2'd2) begin
            count_next = count_shift + 3'd6;
            extra_next = 2'd0;
         end else begin
            count_next = count_shift + 3'd5;
            extra_next = sample_extra + 2'd1;
         end
      end
   end

   always_ff @(posedge clk_sample) begin
      sample_buf <= buf_next;
   end

   always_ff @(posedge clk_sample) begin
      if (reset) begin
         sample_count <= '0;
         sample_extra <= '0;
      end else begin
         sample_count <= count_next;
         sample_extra <= extra_next;
      end
   end

endmodule

//--- rt_data_feed.sv
`timescale 1ns/1ps

module rt_data_feed import feed_pkg::*; #(
   parameter int PAYLOAD_DEPTH = 64
) (
   input  logic        clk_sample,
   input  logic        reset,
   input  feed_word_t  in_word,
   output logic        credit,
   output sample_t     sample,
   output logic        have_data,
   output logic [8:0]  words_available,
   output logic [8:0]  packet_count,
   output logic [8:0]  good_packet_count
);

   localparam int AW = $clog2(PAYLOAD_DEPTH);

   ram_req_t          wr_req;
   logic [AW-1:0]     wr_addr;
   logic              wr_grant;
   ram_req_t          rd_req;
   logic [AW-1:0]     rd_addr;
   logic              rd_grant;
   logic              rd_valid;
   ram_req_t          mem_req;
   logic [AW-1:0]     mem_addr;
   logic [WORD_W-1:0] rd_data;
   logic              read_done;
   logic [AW:0]       commit_ptr;

   ////////////////////////////////////////////////////////////////////////////
   // Input side
   ////////////////////////////////////////////////////////////////////////////

   packet_checker #(
      .PAYLOAD_DEPTH(PAYLOAD_DEPTH)
   ) packet_checker_inst (
      .clk_sample(clk_sample),
      .reset(reset),
      .in_word(in_word),
      .credit(credit),
      .wr_req(wr_req),
      .wr_addr(wr_addr),
      .wr_grant(wr_grant),
      .read_done(read_done),
      .commit_ptr(commit_ptr),
      .packet_count(packet_count),
      .good_packet_count(good_packet_count)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Shared payload memory
   ////////////////////////////////////////////////////////////////////////////

   buffer_arbiter #(
      .PAYLOAD_DEPTH(PAYLOAD_DEPTH)
   ) buffer_arbiter_inst (
      .clk_sample(clk_sample),
      .reset(reset),
      .wr_req(wr_req),
      .wr_addr(wr_addr),
      .rd_req(rd_req),
      .rd_addr(rd_addr),
      .wr_grant(wr_grant),
      .rd_grant(rd_grant),
      .mem_req(mem_req),
      .mem_addr(mem_addr),
      .rd_valid(rd_valid)
   );

   payload_ram #(
      .PAYLOAD_DEPTH(PAYLOAD_DEPTH)
   ) payload_ram_inst (
      .clk_sample(clk_sample),
      .mem_req(mem_req),
      .mem_addr(mem_addr),
      .rd_data(rd_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Output side
   ////////////////////////////////////////////////////////////////////////////

   sample_unpacker #(
      .PAYLOAD_DEPTH(PAYLOAD_DEPTH)
   ) sample_unpacker_inst (
      .clk_sample(clk_sample),
      .reset(reset),
      .commit_ptr(commit_ptr),
      .rd_req(rd_req),
      .rd_addr(rd_addr),
      .rd_grant(rd_grant),
      .rd_valid(rd_valid),
      .rd_data(rd_data),
      .read_done(read_done),
      .sample(sample),
      .have_data(have_data),
      .words_available(words_available)
   );

endmodule

//--- tb_feed_model.svh
`ifndef TB_FEED_MODEL_SVH
`define TB_FEED_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Source credits and expected sample stream
////////////////////////////////////////////////////////////////////////////

integer      seed;
int          credits_held;
int          credits_returned;
int          words_sent;
int          planned_words = 0;
int          pkts_built;
int          bad_built;
logic [15:0] word_q [$];
int          gap_q [$];
bit          bit_q [$];
logic [2:0]  expected_q [$];

function automatic void clear_model();
   word_q.delete();
   gap_q.delete();
   bit_q.delete();
   expected_q.delete();
   credits_held = PAYLOAD_DEPTH;
   credits_returned = 0;
   words_sent = 0;
   pkts_built = 0;
   bad_built = 0;
endfunction

// One pulse on the credit line gives the source one more word
function automatic void note_credit();
   if (credit === 1'b1) begin
      credits_held++;
      credits_returned++;
      assert (credits_held <= PAYLOAD_DEPTH) else begin
         $display("%s: credit pulse arrived with no word outstanding", test_name);
         note_error();
      end
   end
endfunction

function automatic void spend_credit();
   credits_held--;
   words_sent++;
endfunction

function automatic void queue_word(input logic [15:0] w, input int gap_max);
   word_q.push_back(w);
   gap_q.push_back(gap_max == 0 ? 0 : int'($unsigned($random(seed)) % (gap_max + 1)));
   planned_words++;
endfunction

// Payload bits go out LSB first and the earliest bit lands in sample bit 0
function automatic void append_bits(input logic [15:0] w);
   logic [2:0] s;
   for (int i = 0; i < 16; i++)
      bit_q.push_back(w[i]);
   while (bit_q.size() >= 3) begin
      s = {bit_q[2], bit_q[1], bit_q[0]};
      void'(bit_q.pop_front());
      void'(bit_q.pop_front());
      void'(bit_q.pop_front());
      expected_q.push_back(s);
   end
endfunction

function automatic void build_packet(input int len, input bit corrupt, input int gap_max);
   logic [15:0] payload [$];
   logic [15:0] w;
   logic [15:0] sum;
   logic [15:0] mask;
   sum = '0;
   queue_word({SYNC_BYTE, 8'(len)}, gap_max);
   for (int i = 0; i < len; i++) begin
      w = 16'($random(seed));
      sum = sum ^ w;
      payload.push_back(w);
      queue_word(w, gap_max);
   end
   if (corrupt) begin
      mask = 16'($random(seed));
      if (mask == '0)
         mask = 16'h0001;
      sum = sum ^ mask;
      bad_built++;
   end else begin
      foreach (payload[i])
         append_bits(payload[i]);
   end
   queue_word(sum, gap_max);
   pkts_built++;
endfunction

// Junk never carries the sync byte, so the checker must drop it
function automatic void add_junk(input int count, input int gap_max);
   logic [15:0] w;
   for (int i = 0; i < count; i++) begin
      w = 16'($random(seed));
      if (w[15:8] == SYNC_BYTE)
         w[15:8] = ~SYNC_BYTE;
      queue_word(w, gap_max);
   end
endfunction

`endif

//--- tb_rt_data_feed.sv
`timescale 1ns/1ps

module tb_rt_data_feed import feed_pkg::*; ();

   localparam int PAYLOAD_DEPTH = 64;

   logic       clk_sample;
   logic       reset;
   feed_word_t in_word;
   logic       credit;
   sample_t    sample;
   logic       have_data;
   logic [8:0] words_available;
   logic [8:0] packet_count;
   logic [8:0] good_packet_count;

   string test_name = "reset";
   int    error_count = 0;
   int    test_errors = 0;
   int    checks_done = 0;
   int    samples_seen = 0;
   int    tests_run = 0;
   int    cycle_count = 0;

   function automatic void note_error();
      error_count++;
      test_errors++;
   endfunction

   `include "tb_feed_model.svh"

   rt_data_feed #(
      .PAYLOAD_DEPTH(PAYLOAD_DEPTH)
   ) rt_data_feed_inst (
      .clk_sample(clk_sample),
      .reset(reset),
      .in_word(in_word),
      .credit(credit),
      .sample(sample),
      .have_data(have_data),
      .words_available(words_available),
      .packet_count(packet_count),
      .good_packet_count(good_packet_count)
   );

   initial begin
      clk_sample = 1'b0;
      forever #4 clk_sample = ~clk_sample;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   function automatic void check_count(input string what, input int expected,
                                       input int actual);
      checks_done++;
      assert (actual == expected) else begin
         $display("ERROR %s %s expected %0d actual %0d", test_name, what, expected, actual);
         note_error();
      end
   endfunction

   // Every valid sample must be the next one in the expected stream
   function automatic void check_sample();
      logic [2:0] want;
      if (reset === 1'b0 && sample.valid === 1'b1) begin
         samples_seen++;
         checks_done++;
         assert (expected_q.size() != 0) else begin
            $display("%s: sample %0d came out with none expected", test_name, sample.data);
            note_error();
         end
         if (expected_q.size() != 0) begin
            want = expected_q.pop_front();
            assert (sample.data == want) else begin
               $display("ERROR %s sample %0d expected %0d actual %0d",
                        test_name, samples_seen, want, sample.data);
               note_error();
            end
         end
      end
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic apply_reset();
      @(negedge clk_sample);
      reset = 1'b1;
      in_word = '0;
      repeat (3) @(posedge clk_sample);
      @(negedge clk_sample);
      reset = 1'b0;
   endtask

   task automatic next_cycle();
      @(negedge clk_sample);
      note_credit();
      check_sample();
   endtask

   task automatic send_words();
      int          gap;
      logic [15:0] w;
      while (word_q.size() != 0) begin
         gap = gap_q.pop_front();
         w = word_q.pop_front();
         repeat (gap) begin
            next_cycle();
            in_word = '0;
         end
         next_cycle();
         // Source stalls until a credit comes back
         while (credits_held == 0) begin
            in_word = '0;
            next_cycle();
         end
         spend_credit();
         in_word = '{valid: 1'b1, data: w};
      end
      next_cycle();
      in_word = '0;
   endtask

   // Idle once every expected sample is out and the credit line stays low
   // for two cycles, since it trails the pending count by one register
   task automatic wait_idle();
      int quiet;
      quiet = 0;
      while (quiet < 2) begin
         next_cycle();
         if (expected_q.size() == 0 && sample.valid === 1'b0 && credit === 1'b0)
            quiet++;
         else
            quiet = 0;
      end
   endtask

   task automatic run_test(input string name, input int packets, input int bad_pct,
                           input int junk_max, input int gap_max, input bit full_len);
      int len;
      bit corrupt;
      test_name = name;
      test_errors = 0;
      samples_seen = 0;
      clear_model();
      apply_reset();
      for (int i = 0; i < packets; i++) begin
         if (junk_max != 0)
            add_junk(int'($unsigned($random(seed)) % (junk_max + 1)), gap_max);
         len = full_len ? MAX_PAYLOAD : 1 + int'($unsigned($random(seed)) % MAX_PAYLOAD);
         corrupt = bad_pct != 0 &&
                   (i == 1 || int'($unsigned($random(seed)) % 100) < bad_pct);
         build_packet(len, corrupt, gap_max);
      end
      if (junk_max != 0)
         add_junk(junk_max, gap_max);
      send_words();
      wait_idle();
      check_count("packet_count", pkts_built, int'(packet_count));
      check_count("good_packet_count", pkts_built - bad_built, int'(good_packet_count));
      check_count("credits returned", words_sent, credits_returned);
      check_count("words_available", 0, int'(words_available));
      check_count("have_data", 0, int'(have_data));
      tests_run++;
      $display("%s: %0d packets (%0d corrupted), %0d words, %0d samples, %0d errors",
               test_name, pkts_built, bad_built, words_sent, samples_seen, test_errors);
   endtask

   initial begin
      seed = 51;
      reset = 1'b1;
      in_word = '0;
      run_test("good_only", 12, 0, 0, 1, 1'b0);
      run_test("bad_checksum", 16, 35, 0, 1, 1'b0);
      run_test("junk_words", 12, 0, 3, 1, 1'b0);
      run_test("credit_flow", 14, 25, 2, 3, 1'b0);
      // Back to back full packets, paced only by credits
      run_test("burst", 8, 0, 0, 0, 1'b1);
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks_done, error_count);
      if (error_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////////////////////////////////////////

   // Twenty cycles per planned word, plus slack for resets and drains
   function automatic int hang_limit();
      return (planned_words + 40) * 20;
   endfunction

   initial begin
      while (cycle_count <= hang_limit()) begin
         @(posedge clk_sample);
         cycle_count++;
      end
      $display("Timeout: the DUT stopped making progress in test %s after %0d cycles",
               test_name, cycle_count);
      $display(">>> FAIL");
      $finish;
   end

endmodule

//--- tb.f
+incdir+.
feed_pkg.sv
payload_ram.sv
buffer_arbiter.sv
packet_checker.sv
sample_unpacker.sv
rt_data_feed.sv
tb_rt_data_feed.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f \
   --top-module tb_rt_data_feed -o sim_rt_data_feed

./obj_dir/sim_rt_data_feed | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
